// ==== all.f ====
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_tag_array.sv
src/icache_word_bank.sv
src/icache_read_path.sv
src/icache_top.sv
sim/icache_sva.sv
sim/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icache_tb -f all.f -o icache_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== sim/icache_tb.sv ====
// Instruction cache testbench
// Directed and random reads checked against a reference model of tags and
// valid bits, with a memory model that answers line requests after a delay
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  // About 160 reads at no more than 12 cycles each
  localparam int MAX_CYCLES   = 2000;
  localparam int RANDOM_READS = 150;
  localparam logic [31:0] MEM_KEY = 32'hc0de_0000;
  localparam logic [31:0] ADDR_A  = 32'h0001_2340;
  // Same index as ADDR_A, other tag
  localparam logic [31:0] ADDR_B  = 32'h0001_3340;

  logic                                 clk;
  logic                                 rstn;
  icache_pkg::core_req_t                core;
  logic [icache_pkg::DATA_BITS-1:0]     core_out;
  logic                                 core_wait;
  icache_pkg::mem_req_t                 mem_req_o;
  icache_pkg::mem_rsp_t                 mem_rsp;
  logic [icache_pkg::DATA_BITS-1:0]     access_count;
  logic [icache_pkg::DATA_BITS-1:0]     hit_count;
  logic [icache_pkg::DATA_BITS-1:0]     miss_count;

  // Reference model
  logic                                 ref_valid [icache_pkg::LINES];
  logic [icache_pkg::TAG_BITS-1:0]      ref_tag   [icache_pkg::LINES];
  int model_access;
  int model_hit;
  int model_miss;
  int mem_reqs;
  int checks;
  int errors;
  int cycle_count;
  int seed;

  icache_top uut (
    .clk          (clk),
    .rstn         (rstn),
    .core         (core),
    .core_out     (core_out),
    .core_wait    (core_wait),
    .mem_req_o    (mem_req_o),
    .mem_rsp      (mem_rsp),
    .access_count (access_count),
    .hit_count    (hit_count),
    .miss_count   (miss_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ==============================
  // Memory model
  // ==============================
  initial begin
    logic [31:0] line;
    int          delay;
    mem_rsp = '0;
    forever begin
      @(posedge clk);
      #2;
      if (mem_req_o.req) begin
        line  = mem_req_o.addr;
        mem_reqs++;
        delay = $unsigned($random(seed)) % 6;
        repeat (delay) begin
          @(posedge clk);
          #2;
        end
        for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
          mem_rsp.valid = 1'b1;
          mem_rsp.data  = (line + 32'(4 * k)) ^ MEM_KEY;
          @(posedge clk);
          #2;
        end
        mem_rsp = '0;
      end
    end
  end

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_word(input string name, input logic [icache_pkg::DATA_BITS-1:0] expected,
                            input logic [icache_pkg::DATA_BITS-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_count(input string name, input logic [icache_pkg::DATA_BITS-1:0] exp_access,
                             input logic [icache_pkg::DATA_BITS-1:0] exp_hit,
                             input logic [icache_pkg::DATA_BITS-1:0] exp_miss);
    check_word({name, " access_count"}, exp_access, access_count);
    check_word({name, " hit_count"}, exp_hit, hit_count);
    check_word({name, " miss_count"}, exp_miss, miss_count);
  endtask

  // One complete read, started and finished 2 ns after a rising edge
  task automatic read_word(input string name, input logic [31:0] addr);
    icache_pkg::icache_addr_u a;
    logic                     predict_hit;
    int                       reqs_before;
    a.raw       = addr;
    predict_hit = ref_valid[a.fields.index] && (ref_tag[a.fields.index] == a.fields.tag);
    reqs_before = mem_reqs;
    core.req    = 1'b1;
    core.addr   = a;
    @(posedge clk);
    #2;
    core.req = 1'b0;
    check_flag({name, " wait raised"}, 1'b1, core_wait);
    if (predict_hit) begin
      @(posedge clk);
      #2;
      check_flag({name, " wait after hit"}, 1'b0, core_wait);
    end
    while (core_wait) begin
      @(posedge clk);
      #2;
    end
    check_word({name, " data"}, {addr[31:2], 2'b00} ^ MEM_KEY, core_out);
    check_word({name, " mem requests"}, predict_hit ? 32'd0 : 32'd1, 32'(mem_reqs - reqs_before));
    model_access++;
    if (predict_hit) begin
      model_hit++;
    end else begin
      model_miss++;
      ref_valid[a.fields.index] = 1'b1;
      ref_tag[a.fields.index]   = a.fields.tag;
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic after_reset();
    check_flag("reset core_wait", 1'b0, core_wait);
    check_flag("reset mem req", 1'b0, mem_req_o.req);
    check_count("reset", 32'd0, 32'd0, 32'd0);
  endtask

  task automatic cold_miss();
    read_word("cold miss", ADDR_A);
    check_count("cold miss", 32'd1, 32'd0, 32'd1);
  endtask

  task automatic hits_same_line();
    read_word("hit word 1", ADDR_A + 32'h4);
    read_word("hit word 2", ADDR_A + 32'h8);
    read_word("hit word 3", ADDR_A + 32'hc);
    check_count("hits", 32'd4, 32'd3, 32'd1);
  endtask

  task automatic conflict_miss();
    read_word("conflict new tag", ADDR_B);
    read_word("conflict old tag", ADDR_A);
    check_count("conflict", 32'd6, 32'd3, 32'd3);
  endtask

  // Two tags over four indexes, so lines keep evicting each other
  task automatic random_reads();
    icache_pkg::icache_addr_u a;
    for (int n = 0; n < RANDOM_READS; n++) begin
      a               = '0;
      a.fields.tag[0] = 1'($unsigned($random(seed)) % 2);
      a.fields.index  = 6'($unsigned($random(seed)) % 4);
      a.fields.word   = 2'($unsigned($random(seed)) % 4);
      read_word("random", a.raw);
    end
    check_count("random", 32'(model_access), 32'(model_hit), 32'(model_miss));
  endtask

  initial begin
    core         = '0;
    rstn         = 1'b0;
    seed         = 32'h31e4_ea71;
    model_access = 0;
    model_hit    = 0;
    model_miss   = 0;
    mem_reqs     = 0;
    checks       = 0;
    errors       = 0;
    foreach (ref_valid[i]) begin
      ref_valid[i] = 1'b0;
      ref_tag[i]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rstn = 1'b1;
    after_reset();
    cold_miss();
    hits_same_line();
    conflict_miss();
    random_reads();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/icache_sva.sv ====
// Instruction cache protocol checks
// Watches core_wait and the memory request and response bus of the cache top
`timescale 1ns/1ps
`default_nettype none

module icache_sva (
  input logic                 clk,
  input logic                 rstn,
  input logic                 core_wait,
  input icache_pkg::mem_req_t mem_req_o,
  input icache_pkg::mem_rsp_t mem_rsp
);

  logic [2:0] beats_seen;

  // Beats since the last line request
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beats_seen <= '0;
    end else if (mem_req_o.req) begin
      beats_seen <= mem_rsp.valid ? 3'd1 : 3'd0;
    end else if (mem_rsp.valid) begin
      beats_seen <= beats_seen + 3'd1;
    end
  end

  wait_low_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !core_wait)
    else $error("core_wait high right after reset");

  req_single_pulse: assert property (@(posedge clk) disable iff (!rstn)
    mem_req_o.req |=> !mem_req_o.req)
    else $error("mem_req_o.req held longer than one cycle");

  beat_limit: assert property (@(posedge clk) disable iff (!rstn)
    (mem_rsp.valid && !mem_req_o.req) |-> (beats_seen < 3'd4))
    else $error("more than four beats for one line request");

endmodule

bind icache_top icache_sva u_sva (
  .clk       (clk),
  .rstn      (rstn),
  .core_wait (core_wait),
  .mem_req_o (mem_req_o),
  .mem_rsp   (mem_rsp)
);

`default_nettype wire

// ==== src/icache_top.sv ====
// Instruction cache top
// Direct-mapped, read-only, 64 lines of four words
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic                                clk,
  input  logic                                rstn,
  input  icache_pkg::core_req_t               core,
  output logic [icache_pkg::DATA_BITS-1:0]    core_out,
  output logic                                core_wait,
  output icache_pkg::mem_req_t                mem_req_o,
  input  icache_pkg::mem_rsp_t                mem_rsp,
  output logic [icache_pkg::DATA_BITS-1:0]    access_count,
  output logic [icache_pkg::DATA_BITS-1:0]    hit_count,
  output logic [icache_pkg::DATA_BITS-1:0]    miss_count
);

  logic [icache_pkg::TAG_BITS-1:0]                                tag_rd;
  logic [icache_pkg::INDEX_BITS-1:0]                              lookup_index;
  logic                                                           lookup_rd;
  logic                                                           tag_wr;
  logic [icache_pkg::TAG_BITS-1:0]                                tag_wdata;
  icache_pkg::bank_wr_t                                           bank_wr;
  icache_pkg::icache_state_t                                      state;
  logic [icache_pkg::WORD_BITS-1:0]                               word_sel;
  logic                                                           hit;
  logic [icache_pkg::BEAT_BITS-1:0]                               beat;
  logic [icache_pkg::WORDS_PER_LINE-1:0][icache_pkg::DATA_BITS-1:0] bank_rdata;

  // Busy for the whole access
  assign core_wait = (state != icache_pkg::IDLE);

  icache_ctrl u_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .core         (core),
    .mem_req_o    (mem_req_o),
    .mem_rsp      (mem_rsp),
    .tag_rd       (tag_rd),
    .lookup_index (lookup_index),
    .lookup_rd    (lookup_rd),
    .tag_wr       (tag_wr),
    .tag_wdata    (tag_wdata),
    .bank_wr      (bank_wr),
    .state        (state),
    .word_sel     (word_sel),
    .hit          (hit),
    .beat         (beat)
  );

  icache_tag_array u_tag_array (
    .clk   (clk),
    .index (lookup_index),
    .rd    (lookup_rd),
    .wr    (tag_wr),
    .wdata (tag_wdata),
    .rdata (tag_rd)
  );

  for (genvar b = 0; b < icache_pkg::WORDS_PER_LINE; b++) begin : g_bank
    icache_word_bank #(
      .BANK (b)
    ) u_bank (
      .clk   (clk),
      .index (lookup_index),
      .rd    (lookup_rd),
      .wr    (bank_wr),
      .rdata (bank_rdata[b])
    );
  end

  icache_read_path u_read_path (
    .clk          (clk),
    .rstn         (rstn),
    .state        (state),
    .word_sel     (word_sel),
    .hit          (hit),
    .beat         (beat),
    .beat_data    (mem_rsp.data),
    .bank_rdata   (bank_rdata),
    .core         (core),
    .core_out     (core_out),
    .access_count (access_count),
    .hit_count    (hit_count),
    .miss_count   (miss_count)
  );

endmodule

`default_nettype wire

// ==== src/icache_read_path.sv ====
// Instruction cache read path
// Picks the answer from the banks on a hit or from the refill beats on a miss,
// registers core_out and keeps the access, hit and miss counters
`timescale 1ns/1ps
`default_nettype none

module icache_read_path (
  input  logic                                                     clk,
  input  logic                                                     rstn,
  input  icache_pkg::icache_state_t                                state,
  input  logic [icache_pkg::WORD_BITS-1:0]                         word_sel,
  input  logic                                                     hit,
  input  logic [icache_pkg::BEAT_BITS-1:0]                         beat,
  input  logic [icache_pkg::DATA_BITS-1:0]                         beat_data,
  input  logic [icache_pkg::WORDS_PER_LINE-1:0][icache_pkg::DATA_BITS-1:0] bank_rdata,
  input  icache_pkg::core_req_t                                    core,
  output logic [icache_pkg::DATA_BITS-1:0]                         core_out,
  output logic [icache_pkg::DATA_BITS-1:0]                         access_count,
  output logic [icache_pkg::DATA_BITS-1:0]                         hit_count,
  output logic [icache_pkg::DATA_BITS-1:0]                         miss_count
);

  logic [icache_pkg::DATA_BITS-1:0] fill_word;
  logic                             fill_take;
  logic                             fill_done;

  // Beats are numbered from one, word offsets from zero
  assign fill_take = (state == icache_pkg::REFILL) && (beat == {1'b0, word_sel} + 1'b1);
  assign fill_done = (state == icache_pkg::REFILL) && (beat == icache_pkg::FILL_DONE);

  always_ff @(posedge clk) begin
    if (fill_take) begin
      fill_word <= beat_data;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      core_out <= '0;
    end else if (hit) begin
      core_out <= bank_rdata[word_sel];
    end else if (fill_done) begin
      // Requested word may be the last beat itself
      core_out <= fill_take ? beat_data : fill_word;
    end
  end

  // ==============================
  // Performance counters
  // ==============================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      access_count <= '0;
      hit_count    <= '0;
      miss_count   <= '0;
    end else begin
      if ((state == icache_pkg::IDLE) && core.req) begin
        access_count <= access_count + 1'b1;
      end
      if (hit) begin
        hit_count <= hit_count + 1'b1;
      end
      if (fill_done) begin
        miss_count <= miss_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_word_bank.sv ====
// Instruction cache word bank
// Holds one word position of every line, written by its own refill beat
`timescale 1ns/1ps
`default_nettype none

module icache_word_bank #(
  parameter int BANK = 0
) (
  input  logic                                clk,
  input  logic [icache_pkg::INDEX_BITS-1:0]   index,
  input  logic                                rd,
  input  icache_pkg::bank_wr_t                wr,
  output logic [icache_pkg::DATA_BITS-1:0]    rdata
);

  logic [icache_pkg::DATA_BITS-1:0] mem [icache_pkg::LINES];

  always_ff @(posedge clk) begin
    if (wr.wen[BANK]) begin
      mem[wr.index] <= wr.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_tag_array.sv ====
// Instruction cache tag array
// Single-port tag storage, one entry per line, registered read
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array (
  input  logic                                clk,
  input  logic [icache_pkg::INDEX_BITS-1:0]   index,
  input  logic                                rd,
  input  logic                                wr,
  input  logic [icache_pkg::TAG_BITS-1:0]     wdata,
  output logic [icache_pkg::TAG_BITS-1:0]     rdata
);

  logic [icache_pkg::TAG_BITS-1:0] mem [icache_pkg::LINES];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[index] <= wdata;
    end
  end

  // Output holds between reads
  always_ff @(posedge clk) begin
    if (rd) begin
      rdata <= mem[index];
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_ctrl.sv ====
// Instruction cache controller
// Runs the IDLE/CHK/REFILL FSM, holds the valid bits and the captured request,
// and steers refill beats into the tag array and word banks
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  icache_pkg::core_req_t                  core,
  output icache_pkg::mem_req_t                   mem_req_o,
  input  icache_pkg::mem_rsp_t                   mem_rsp,
  input  logic [icache_pkg::TAG_BITS-1:0]        tag_rd,
  output logic [icache_pkg::INDEX_BITS-1:0]      lookup_index,
  output logic                                   lookup_rd,
  output logic                                   tag_wr,
  output logic [icache_pkg::TAG_BITS-1:0]        tag_wdata,
  output icache_pkg::bank_wr_t                   bank_wr,
  output icache_pkg::icache_state_t              state,
  output logic [icache_pkg::WORD_BITS-1:0]       word_sel,
  output logic                                   hit,
  output logic [icache_pkg::BEAT_BITS-1:0]       beat
);

  icache_pkg::icache_state_t        state_d;
  icache_pkg::icache_addr_u         req_addr;
  icache_pkg::icache_addr_u         line_addr;
  logic [icache_pkg::LINES-1:0]     valid;
  logic [icache_pkg::BEAT_BITS-1:0] beat_cnt;
  logic                             beat_in;
  logic                             last_beat;
  logic                             req_q;

  assign beat_in   = (state == icache_pkg::REFILL) && mem_rsp.valid;
  assign last_beat = beat_in && (beat_cnt == icache_pkg::LAST_BEAT);

  // ==============================
  // Lookup and compare
  // ==============================
  // New address while idle, captured one afterwards
  assign lookup_index = (state == icache_pkg::IDLE) ? core.addr.fields.index
                                                     : req_addr.fields.index;
  assign lookup_rd    = (state == icache_pkg::IDLE) && core.req;

  assign hit      = (state == icache_pkg::CHK) && (tag_rd == req_addr.fields.tag);
  assign word_sel = req_addr.fields.word;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      req_addr <= '0;
    end else if (lookup_rd) begin
      req_addr <= core.addr;
    end
  end

  // ==============================
  // FSM
  // ==============================
  always_comb begin
    state_d = state;
    case (state)
      icache_pkg::IDLE: begin
        if (core.req) begin
          // Invalid line goes straight to refill
          state_d = valid[core.addr.fields.index] ? icache_pkg::CHK : icache_pkg::REFILL;
        end
      end
      icache_pkg::CHK: begin
        state_d = hit ? icache_pkg::IDLE : icache_pkg::REFILL;
      end
      icache_pkg::REFILL: begin
        if (last_beat) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= icache_pkg::IDLE;
      req_q <= 1'b0;
    end else begin
      state <= state_d;
      // Pulse on the first refill cycle only
      req_q <= (state != icache_pkg::REFILL) && (state_d == icache_pkg::REFILL);
    end
  end

  // ==============================
  // Refill
  // ==============================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt <= '0;
      valid    <= '0;
    end else if (last_beat) begin
      beat_cnt                     <= '0;
      valid[req_addr.fields.index] <= 1'b1;
    end else if (beat_in) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  // Tag goes in with the first beat
  assign tag_wr    = beat_in && (beat_cnt == '0);
  assign tag_wdata = req_addr.fields.tag;

  always_comb begin
    bank_wr       = '0;
    bank_wr.index = req_addr.fields.index;
    bank_wr.data  = mem_rsp.data;
    if (beat_in) begin
      bank_wr.wen[beat_cnt[icache_pkg::WORD_BITS-1:0]] = 1'b1;
    end
  end

  // Numbered 1..4 while a beat is on the bus, zero otherwise
  assign beat = beat_in ? beat_cnt + 1'b1 : '0;

  always_comb begin
    line_addr               = req_addr;
    line_addr.fields.word   = '0;
    line_addr.fields.offset = '0;
  end

  assign mem_req_o.req  = req_q;
  assign mem_req_o.addr = line_addr.raw;

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
// Instruction cache shared definitions
// Geometry, the two views of an address and the port bundles
`default_nettype none

package icache_pkg;

  // ==============================
  // Geometry
  // ==============================
  localparam int ADDR_BITS      = 32;
  localparam int DATA_BITS      = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_BITS      = 2;
  localparam int BYTE_BITS      = 2;
  localparam int INDEX_BITS     = 6;
  localparam int LINES          = 64;
  localparam int TAG_BITS       = ADDR_BITS - INDEX_BITS - WORD_BITS - BYTE_BITS;
  localparam int BEAT_BITS      = 3;

  // Beat counter values for the last write and the finished refill
  localparam logic [BEAT_BITS-1:0] LAST_BEAT = BEAT_BITS'(WORDS_PER_LINE - 1);
  localparam logic [BEAT_BITS-1:0] FILL_DONE = BEAT_BITS'(WORDS_PER_LINE);

  // ==============================
  // Address views
  // ==============================
  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic [WORD_BITS-1:0]  word;
    logic [BYTE_BITS-1:0]  offset;
  } addr_fields_t;

  typedef union packed {
    logic [ADDR_BITS-1:0] raw;
    addr_fields_t         fields;
  } icache_addr_u;

  // ==============================
  // Bundles
  // ==============================
  typedef struct packed {
    logic         req;
    icache_addr_u addr;
  } core_req_t;

  // Line address, word and byte bits always zero
  typedef struct packed {
    logic                 req;
    logic [ADDR_BITS-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic                 valid;
    logic [DATA_BITS-1:0] data;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    CHK,
    REFILL
  } icache_state_t;

  // One refill beat broadcast to all word banks
  typedef struct packed {
    logic [WORDS_PER_LINE-1:0] wen;
    logic [INDEX_BITS-1:0]     index;
    logic [DATA_BITS-1:0]      data;
  } bank_wr_t;

endpackage

`default_nettype wire
